// ==== common/int_issue_macros.svh ====
`ifndef INT_ISSUE_MACROS_SVH
`define INT_ISSUE_MACROS_SVH

// datapath width
`define XLEN        32

// physical register file, register 0 reads zero
`define PHY_REGS    64
`define PHY_IDX     6

// architectural register index and ROB id widths
`define ARCH_IDX    5
`define ROB_IDX     5

// reservation station sizing
`define INTRS_DEPTH 8
`define INTRS_IDX   3

// dispatch lanes per cycle
`define ID_WIDTH    2

// broadcast slots, slot 0 is the ALU and slot 1 is external
`define CDB_WIDTH   2

`endif

// ==== common/int_issue_pkg.sv ====
`default_nettype none

`include "int_issue_macros.svh"

package int_issue_pkg;

    // alu opcodes
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA
    } alu_op_t;

    // source of the second alu operand
    typedef enum logic {
        RS2,
        IMM
    } op2_sel_t;

    // what a station slot loads at the next edge
    typedef enum logic [1:0] {
        SELF,
        PREV,
        PUSH_IN
    } rs_update_sel_t;

    // renamed micro-op as it leaves dispatch
    typedef struct packed {
        logic [`ROB_IDX-1:0]    rob_id;
        logic [`PHY_IDX-1:0]    rs1_phy;
        logic                   rs1_valid;
        logic [`PHY_IDX-1:0]    rs2_phy;
        logic                   rs2_valid;
        logic [`PHY_IDX-1:0]    rd_phy;
        logic [`ARCH_IDX-1:0]   rd_arch;
        op2_sel_t               op2_sel;
        logic [`XLEN-1:0]       imm;
        alu_op_t                fu_opcode;
    } int_uop_t;

    // payload held by one station slot
    typedef struct packed {
        logic [`ROB_IDX-1:0]    rob_id;
        logic [`PHY_IDX-1:0]    rs1_phy;
        logic                   rs1_valid;
        logic [`PHY_IDX-1:0]    rs2_phy;
        logic                   rs2_valid;
        logic [`PHY_IDX-1:0]    rd_phy;
        logic [`ARCH_IDX-1:0]   rd_arch;
        op2_sel_t               op2_sel;
        logic [`XLEN-1:0]       imm;
        alu_op_t                fu_opcode;
    } int_rs_entry_t;

    // one result broadcast
    typedef struct packed {
        logic                   valid;
        logic [`ROB_IDX-1:0]    rob_id;
        logic [`PHY_IDX-1:0]    rd_phy;
        logic [`ARCH_IDX-1:0]   rd_arch;
        logic [`XLEN-1:0]       value;
    } cdb_t;

    // operands and tags for the alu
    typedef struct packed {
        logic [`ROB_IDX-1:0]    rob_id;
        logic [`PHY_IDX-1:0]    rd_phy;
        logic [`ARCH_IDX-1:0]   rd_arch;
        op2_sel_t               op2_sel;
        alu_op_t                fu_opcode;
        logic [`XLEN-1:0]       imm;
        logic [`XLEN-1:0]       rs1_value;
        logic [`XLEN-1:0]       rs2_value;
    } fu_alu_reg_t;

endpackage

`default_nettype wire

// ==== verilog/one_hot_mux.sv ====
`default_nettype none

module one_hot_mux #(
    parameter type T          = logic,
    parameter int  NUM_INPUTS = 2
) (
    input  wire T                       data_in [NUM_INPUTS],
    input  wire logic [NUM_INPUTS-1:0]  select,
    output T                            data_out
);

    // and-or tree, zero when nothing is selected
    always_comb begin
        data_out = T'('0);
        for (int i = 0; i < NUM_INPUTS; i++) begin
            if (select[i]) begin
                data_out = T'(data_out | data_in[i]);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fu_alu.sv ====
`default_nettype none

`include "int_issue_macros.svh"

module fu_alu (
    input  wire logic                       clk,
    input  wire logic                       rst,

    input  wire logic                       issue,
    input  wire int_issue_pkg::fu_alu_reg_t alu_in,

    output int_issue_pkg::cdb_t             cdb
);
    import int_issue_pkg::*;

    logic [`XLEN-1:0]       op1;
    logic [`XLEN-1:0]       op2;
    logic [4:0]             shamt;
    logic [`XLEN-1:0]       result;

    logic                   valid_q;
    logic [`ROB_IDX-1:0]    rob_id_q;
    logic [`PHY_IDX-1:0]    rd_phy_q;
    logic [`ARCH_IDX-1:0]   rd_arch_q;
    logic [`XLEN-1:0]       value_q;

    assign op1   = alu_in.rs1_value;
    assign op2   = (alu_in.op2_sel == IMM) ? alu_in.imm : alu_in.rs2_value;
    assign shamt = op2[4:0];

    always_comb begin
        case (alu_in.fu_opcode)
            ADD:     result = op1 + op2;
            SUB:     result = op1 - op2;
            AND:     result = op1 & op2;
            OR:      result = op1 | op2;
            XOR:     result = op1 ^ op2;
            SLT:     result = {{(`XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            SLTU:    result = {{(`XLEN-1){1'b0}}, op1 < op2};
            SLL:     result = op1 << shamt;
            SRL:     result = op1 >> shamt;
            SRA:     result = $signed(op1) >>> shamt;
            default: result = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // result register, drives the alu broadcast slot
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue;
        end
    end

    always_ff @(posedge clk) begin
        rob_id_q  <= alu_in.rob_id;
        rd_phy_q  <= alu_in.rd_phy;
        rd_arch_q <= alu_in.rd_arch;
        value_q   <= result;
    end

    assign cdb.valid   = valid_q;
    assign cdb.rob_id  = rob_id_q;
    assign cdb.rd_phy  = rd_phy_q;
    assign cdb.rd_arch = rd_arch_q;
    assign cdb.value   = value_q;

endmodule

`default_nettype wire

// ==== verilog/phys_reg_file.sv ====
`default_nettype none

`include "int_issue_macros.svh"

module phys_reg_file (
    input  wire logic                   clk,
    input  wire logic                   rst,

    input  wire int_issue_pkg::cdb_t    cdb [`CDB_WIDTH],

    input  wire logic [`PHY_IDX-1:0]    rs1_phy,
    input  wire logic [`PHY_IDX-1:0]    rs2_phy,
    output logic [`XLEN-1:0]            rs1_value,
    output logic [`XLEN-1:0]            rs2_value
);

    logic [`XLEN-1:0] regs [`PHY_REGS];

    // every broadcast slot writes, tags are unique per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `PHY_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int s = 0; s < `CDB_WIDTH; s++) begin
                if (cdb[s].valid) begin
                    regs[cdb[s].rd_phy] <= cdb[s].value;
                end
            end
        end
    end

    // p0 is hardwired to zero
    assign rs1_value = (rs1_phy == '0) ? '0 : regs[rs1_phy];
    assign rs2_value = (rs2_phy == '0) ? '0 : regs[rs2_phy];

endmodule

`default_nettype wire

// ==== int_rs/int_rs_entry.sv ====
`default_nettype none

`include "int_issue_macros.svh"

module int_rs_entry (
    input  wire logic                           clk,
    input  wire logic                           rst,

    input  wire int_issue_pkg::rs_update_sel_t  update_sel,
    input  wire int_issue_pkg::int_rs_entry_t   entry_in,
    input  wire logic                           entry_in_valid,
    input  wire int_issue_pkg::cdb_t            cdb [`CDB_WIDTH],

    output logic                                valid,
    output logic                                request,
    input  wire logic                           grant,
    output int_issue_pkg::int_rs_entry_t        entry
);
    import int_issue_pkg::*;

    int_rs_entry_t  entry_next;
    logic           valid_next;

    // pick the next payload, then wake its sources from every slot
    always_comb begin
        entry_next = (update_sel == SELF) ? entry : entry_in;
        for (int s = 0; s < `CDB_WIDTH; s++) begin
            if (cdb[s].valid) begin
                if (cdb[s].rd_phy == entry_next.rs1_phy) begin
                    entry_next.rs1_valid = 1'b1;
                end
                if (cdb[s].rd_phy == entry_next.rs2_phy) begin
                    entry_next.rs2_valid = 1'b1;
                end
            end
        end
    end

    // an empty shift arrives as PREV with entry_in_valid low
    always_comb begin
        case (update_sel)
            SELF:    valid_next = valid && !grant;
            PREV:    valid_next = entry_in_valid;
            PUSH_IN: valid_next = entry_in_valid;
            default: valid_next = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else begin
            valid <= valid_next;
        end
    end

    always_ff @(posedge clk) begin
        entry <= entry_next;
    end

    // immediate ops never wait on rs2
    assign request = valid && entry.rs1_valid
                   && (entry.rs2_valid || (entry.op2_sel == IMM));

endmodule

`default_nettype wire

// ==== int_rs/int_rs.sv ====
`default_nettype none

`include "int_issue_macros.svh"

module int_rs (
    input  wire logic                           clk,
    input  wire logic                           rst,

    input  wire logic [`ID_WIDTH-1:0]           dispatch_valid,
    input  wire int_issue_pkg::int_uop_t        dispatch_uop [`ID_WIDTH],
    output logic                                dispatch_ready,

    input  wire int_issue_pkg::cdb_t            cdb [`CDB_WIDTH],

    output logic [`PHY_IDX-1:0]                 rs1_phy,
    output logic [`PHY_IDX-1:0]                 rs2_phy,
    input  wire logic [`XLEN-1:0]               rs1_value,
    input  wire logic [`XLEN-1:0]               rs2_value,

    output int_issue_pkg::cdb_t                 alu_cdb
);
    import int_issue_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // slot array
    //////////////////////////////////////////////////////////////////////

    logic [`INTRS_DEPTH-1:0]    rs_valid;
    logic [`INTRS_DEPTH-1:0]    rs_above_valid;
    logic [`INTRS_DEPTH-1:0]    rs_request;
    logic [`INTRS_DEPTH-1:0]    rs_grant;
    logic [`INTRS_DEPTH-1:0]    rs_entry_in_valid;
    int_rs_entry_t              rs_entry [`INTRS_DEPTH];
    int_rs_entry_t              rs_entry_in [`INTRS_DEPTH];
    int_rs_entry_t              rs_above [`INTRS_DEPTH];
    rs_update_sel_t             rs_update_sel [`INTRS_DEPTH];
    int_rs_entry_t              ds_entry [`ID_WIDTH];
    int_rs_entry_t              issued_entry;

    // queue top, one bit wider so a full station reads as INTRS_DEPTH
    logic [`INTRS_IDX:0]        rs_top;
    logic [`INTRS_IDX:0]        rs_top_next;
    logic [`INTRS_IDX:0]        rs_push_idx [`ID_WIDTH];
    logic [`INTRS_IDX:0]        rs_free_cnt;
    logic [`ID_WIDTH-1:0]       rs_push_en;
    logic [`INTRS_IDX-1:0]      rs_issue_idx;
    logic                       rs_pop;
    fu_alu_reg_t                alu_in;

    always_comb begin
        for (int w = 0; w < `ID_WIDTH; w++) begin
            ds_entry[w].rob_id    = dispatch_uop[w].rob_id;
            ds_entry[w].rs1_phy   = dispatch_uop[w].rs1_phy;
            ds_entry[w].rs1_valid = dispatch_uop[w].rs1_valid;
            ds_entry[w].rs2_phy   = dispatch_uop[w].rs2_phy;
            ds_entry[w].rs2_valid = dispatch_uop[w].rs2_valid;
            ds_entry[w].rd_phy    = dispatch_uop[w].rd_phy;
            ds_entry[w].rd_arch   = dispatch_uop[w].rd_arch;
            ds_entry[w].op2_sel   = dispatch_uop[w].op2_sel;
            ds_entry[w].imm       = dispatch_uop[w].imm;
            ds_entry[w].fu_opcode = dispatch_uop[w].fu_opcode;
        end
    end

    for (genvar i = 0; i < `INTRS_DEPTH; i++) begin : rs_array
        // shift source, the last slot sees an empty slot above
        if (i < `INTRS_DEPTH - 1) begin : g_above
            assign rs_above[i] = rs_entry[i+1];
        end else begin : g_last
            assign rs_above[i] = '0;
        end

        int_rs_entry u_entry (
            .clk            (clk),
            .rst            (rst),
            .update_sel     (rs_update_sel[i]),
            .entry_in       (rs_entry_in[i]),
            .entry_in_valid (rs_entry_in_valid[i]),
            .cdb            (cdb),
            .valid          (rs_valid[i]),
            .request        (rs_request[i]),
            .grant          (rs_grant[i]),
            .entry          (rs_entry[i])
        );
    end

    // valid bit of the slot above, zero past the last slot
    assign rs_above_valid = rs_valid >> 1;

    //////////////////////////////////////////////////////////////////////
    // pop, push and compaction
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rs_top <= '0;
        end else begin
            rs_top <= rs_top_next;
        end
    end

    // pushes land above the post-pop top
    always_comb begin
        rs_top_next = rs_top - {{`INTRS_IDX{1'b0}}, rs_pop};
        for (int j = 0; j < `ID_WIDTH; j++) begin
            rs_push_en[j] = dispatch_valid[j] && dispatch_ready;
            rs_push_idx[j] = rs_top_next;
            if (rs_push_en[j]) begin
                rs_top_next = rs_top_next + 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `INTRS_DEPTH; i++) begin
            rs_update_sel[i] = SELF;
            rs_entry_in[i] = rs_above[i];
            rs_entry_in_valid[i] = rs_above_valid[i];
            if (rs_pop && (i >= rs_issue_idx)) begin
                rs_update_sel[i] = PREV;
            end
            for (int j = 0; j < `ID_WIDTH; j++) begin
                if (rs_push_en[j] && (rs_push_idx[j] == i)) begin
                    rs_update_sel[i] = PUSH_IN;
                    rs_entry_in[i] = ds_entry[j];
                    rs_entry_in_valid[i] = 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // issue select and dispatch ready
    //////////////////////////////////////////////////////////////////////

    // scan from the top so the lowest requesting slot wins
    always_comb begin
        rs_grant = '0;
        rs_issue_idx = '0;
        for (int i = `INTRS_DEPTH - 1; i >= 0; i--) begin
            if (rs_request[i]) begin
                rs_grant = `INTRS_DEPTH'(1) << i;
                rs_issue_idx = i[`INTRS_IDX-1:0];
            end
        end
    end

    assign rs_pop = |rs_grant;

    one_hot_mux #(
        .T          (int_rs_entry_t),
        .NUM_INPUTS (`INTRS_DEPTH)
    ) u_issue_mux (
        .data_in    (rs_entry),
        .select     (rs_grant),
        .data_out   (issued_entry)
    );

    // free slots before this cycle's pop
    always_comb begin
        rs_free_cnt = '0;
        for (int i = 0; i < `INTRS_DEPTH; i++) begin
            if (!rs_valid[i]) begin
                rs_free_cnt = rs_free_cnt + 1'b1;
            end
        end
    end

    assign dispatch_ready = (rs_free_cnt >= `ID_WIDTH);

    //////////////////////////////////////////////////////////////////////
    // operand read and alu
    //////////////////////////////////////////////////////////////////////

    assign rs1_phy = issued_entry.rs1_phy;
    assign rs2_phy = issued_entry.rs2_phy;

    always_comb begin
        alu_in.rob_id    = issued_entry.rob_id;
        alu_in.rd_phy    = issued_entry.rd_phy;
        alu_in.rd_arch   = issued_entry.rd_arch;
        alu_in.op2_sel   = issued_entry.op2_sel;
        alu_in.fu_opcode = issued_entry.fu_opcode;
        alu_in.imm       = issued_entry.imm;
        alu_in.rs1_value = rs1_value;
        alu_in.rs2_value = rs2_value;
    end

    fu_alu u_alu (
        .clk    (clk),
        .rst    (rst),
        .issue  (rs_pop),
        .alu_in (alu_in),
        .cdb    (alu_cdb)
    );

endmodule

`default_nettype wire

// ==== verilog/int_issue_top.sv ====
`default_nettype none

`include "int_issue_macros.svh"

module int_issue_top (
    input  wire logic                       clk,
    input  wire logic                       rst,

    input  wire logic [`ID_WIDTH-1:0]       dispatch_valid,
    input  wire int_issue_pkg::int_uop_t    dispatch_uop [`ID_WIDTH],
    output logic                            dispatch_ready,

    input  wire int_issue_pkg::cdb_t        ext_cdb,
    output int_issue_pkg::cdb_t             alu_cdb
);
    import int_issue_pkg::*;

    cdb_t               cdb_bus [`CDB_WIDTH];
    logic [`PHY_IDX-1:0] rs1_phy;
    logic [`PHY_IDX-1:0] rs2_phy;
    logic [`XLEN-1:0]   rs1_value;
    logic [`XLEN-1:0]   rs2_value;

    // slot 0 alu, slot 1 external unit
    assign cdb_bus[0] = alu_cdb;
    assign cdb_bus[1] = ext_cdb;

    int_rs u_int_rs (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_uop   (dispatch_uop),
        .dispatch_ready (dispatch_ready),
        .cdb            (cdb_bus),
        .rs1_phy        (rs1_phy),
        .rs2_phy        (rs2_phy),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .alu_cdb        (alu_cdb)
    );

    phys_reg_file u_prf (
        .clk            (clk),
        .rst            (rst),
        .cdb            (cdb_bus),
        .rs1_phy        (rs1_phy),
        .rs2_phy        (rs2_phy),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value)
    );

endmodule

`default_nettype wire

// ==== verif/int_issue_props.sv ====
`default_nettype none

`include "int_issue_macros.svh"

module int_issue_props (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic [`INTRS_DEPTH-1:0]    valid,
    input  wire logic [`INTRS_DEPTH-1:0]    request,
    input  wire logic [`INTRS_DEPTH-1:0]    grant,
    input  wire logic                       dispatch_ready,
    input  wire logic [`INTRS_IDX:0]        top
);

    // at most one slot issues, and it is the lowest requesting one
    grant_oldest: assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant) && (grant == (request & (~request + 1'b1))))
        else $error("issue grant is not the oldest requesting slot");

    // occupancy cannot grow across a cycle with ready low
    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        !dispatch_ready |=> ($countones(valid) <= $past($countones(valid))))
        else $error("dispatch lane accepted while ready is low");

    top_in_range: assert property (@(posedge clk) disable iff (rst) top <= `INTRS_DEPTH)
        else $error("queue top beyond station depth");

endmodule

bind int_rs int_issue_props u_props (
    .clk            (clk),
    .rst            (rst),
    .valid          (rs_valid),
    .request        (rs_request),
    .grant          (rs_grant),
    .dispatch_ready (dispatch_ready),
    .top            (rs_top)
);

`default_nettype wire

// ==== verif/int_issue_tb.sv ====
`default_nettype none

`include "int_issue_macros.svh"

module int_issue_tb;
    import int_issue_pkg::*;

    typedef struct {
        alu_op_t    op;
        int         rs1;
        int         rs2;
        op2_sel_t   sel;
        logic [31:0] imm;
        int         rd;
        int         lane;
    } row_t;

    // first row, row count, external tag (0 if none), expect full, check order
    typedef struct {
        string      name;
        int         first;
        int         count;
        int         ext_reg;
        bit         full;
        bit         ordered;
    } test_t;

    localparam int TIMEOUT = 200;

    logic                   clk;
    logic                   rst;
    logic [`ID_WIDTH-1:0]   dispatch_valid;
    int_uop_t               dispatch_uop [`ID_WIDTH];
    logic                   dispatch_ready;
    cdb_t                   ext_cdb;
    cdb_t                   alu_cdb;

    row_t               rows [$];
    test_t              tests [$];
    logic [31:0]        model_val [`PHY_REGS];
    bit                 reg_ready [`PHY_REGS];
    logic [31:0]        exp_val [32];
    int                 exp_rd [32];
    bit                 pending [32];
    int                 done_seq [32];
    int                 done_cnt;
    int                 errors;
    logic [31:0]        seed;

    int_issue_top dut (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_uop   (dispatch_uop),
        .dispatch_ready (dispatch_ready),
        .ext_cdb        (ext_cdb),
        .alu_cdb        (alu_cdb)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // expected alu result from the operation rules
    function automatic logic [31:0] alu_ref(alu_op_t op, logic [31:0] a, logic [31:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:    return (a < b) ? 32'd1 : 32'd0;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SRA:     return 32'($signed(a) >>> b[4:0]);
            default: return 32'd0;
        endcase
    endfunction

    task automatic add_row(alu_op_t op, int rs1, int rs2, op2_sel_t sel, logic [31:0] imm,
                           int rd, int lane);
        row_t r;
        r.op = op;
        r.rs1 = rs1;
        r.rs2 = rs2;
        r.sel = sel;
        r.imm = imm;
        r.rd = rd;
        r.lane = lane;
        rows.push_back(r);
    endtask

    task automatic add_test(string name, int first, int count, int ext_reg, bit full,
                            bit ordered);
        test_t t;
        t.name = name;
        t.first = first;
        t.count = count;
        t.ext_reg = ext_reg;
        t.full = full;
        t.ordered = ordered;
        tests.push_back(t);
    endtask

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // monitor, samples on the falling edge
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst && ext_cdb.valid) begin
            reg_ready[ext_cdb.rd_phy] = 1'b1;
        end
        if (!rst && alu_cdb.valid) begin
            assert (pending[alu_cdb.rob_id]) else begin
                $display("unexpected broadcast for rob id %0d at %0t", alu_cdb.rob_id, $time);
                errors++;
            end
            check_val("alu_cdb.value", alu_cdb.value, exp_val[alu_cdb.rob_id]);
            check_val("alu_cdb.rd_phy", alu_cdb.rd_phy, exp_rd[alu_cdb.rob_id]);
            check_val("alu_cdb.rd_arch", alu_cdb.rd_arch, exp_rd[alu_cdb.rob_id] % 32);
            pending[alu_cdb.rob_id] = 1'b0;
            done_seq[alu_cdb.rob_id] = done_cnt;
            done_cnt++;
            reg_ready[alu_cdb.rd_phy] = 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    task automatic send_ext(int rd, logic [31:0] value);
        @(posedge clk);
        ext_cdb.valid <= 1'b1;
        ext_cdb.rob_id <= 5'd31;
        ext_cdb.rd_phy <= rd[`PHY_IDX-1:0];
        ext_cdb.rd_arch <= rd[4:0];
        ext_cdb.value <= value;
        @(posedge clk);
        ext_cdb.valid <= 1'b0;
    endtask

    // builds the uop and records what the model expects from it
    task automatic make_uop(int i, output int_uop_t u);
        row_t r;
        logic [31:0] b;
        r = rows[i];
        u = '0;
        u.rob_id = i[`ROB_IDX-1:0];
        u.rs1_phy = r.rs1[`PHY_IDX-1:0];
        u.rs1_valid = reg_ready[r.rs1];
        u.rs2_phy = (r.sel == IMM) ? '0 : r.rs2[`PHY_IDX-1:0];
        u.rs2_valid = (r.sel == IMM) ? 1'b1 : reg_ready[r.rs2];
        u.rd_phy = r.rd[`PHY_IDX-1:0];
        u.rd_arch = r.rd[4:0];
        u.op2_sel = r.sel;
        u.imm = r.imm;
        u.fu_opcode = r.op;
        b = (r.sel == IMM) ? r.imm : model_val[r.rs2];
        exp_val[i] = alu_ref(r.op, model_val[r.rs1], b);
        exp_rd[i] = r.rd;
        model_val[r.rd] = exp_val[i];
        pending[i] = 1'b1;
    endtask

    // drives one or two lanes and holds them until ready is seen
    task automatic dispatch(int a, int b);
        int_uop_t ua;
        int_uop_t ub;
        int n;
        @(posedge clk);
        make_uop(a, ua);
        dispatch_valid <= '0;
        dispatch_valid[rows[a].lane] <= 1'b1;
        dispatch_uop[rows[a].lane] <= ua;
        if (b >= 0) begin
            make_uop(b, ub);
            dispatch_valid[rows[b].lane] <= 1'b1;
            dispatch_uop[rows[b].lane] <= ub;
        end
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!dispatch_ready && n < TIMEOUT);
        assert (dispatch_ready) else begin
            $display("dispatch_ready never came back for row %0d", a);
            errors++;
        end
    endtask

    task automatic run_test(int t);
        test_t tc;
        int i;
        int base;
        int n;
        int err0;
        tc = tests[t];
        err0 = errors;
        base = done_cnt;
        if (tc.ext_reg != 0) begin
            model_val[tc.ext_reg] = lcg_next();
        end
        i = tc.first;
        while (i < tc.first + tc.count) begin
            if (i + 1 < tc.first + tc.count && rows[i].lane == 0 && rows[i+1].lane == 1) begin
                dispatch(i, i + 1);
                i += 2;
            end else begin
                dispatch(i, -1);
                i++;
            end
        end
        @(posedge clk);
        dispatch_valid <= '0;
        if (tc.ext_reg != 0) begin
            repeat (5) @(negedge clk);
            assert (done_cnt == base) else begin
                $display("ops finished before their external tag was sent");
                errors++;
            end
            if (tc.full) begin
                check_val("dispatch_ready", dispatch_ready, 1'b0);
            end
            send_ext(tc.ext_reg, model_val[tc.ext_reg]);
        end
        n = 0;
        while (done_cnt - base < tc.count && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        repeat (4) @(negedge clk);
        for (int k = tc.first; k < tc.first + tc.count; k++) begin
            assert (!pending[k]) else begin
                $display("timeout, rob id %0d never broadcast", k);
                errors++;
            end
            if (tc.ordered && k > tc.first) begin
                assert (done_seq[k] > done_seq[k-1]) else begin
                    $display("rob id %0d finished before older rob id %0d", k, k - 1);
                    errors++;
                end
            end
        end
        check_val("dispatch_ready", dispatch_ready, 1'b1);
        $display("test %0d %s: %s", t + 1, tc.name, (errors == err0) ? "ok" : "FAILED");
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus table and main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int failed;
        clk = 1'b0;
        rst = 1'b1;
        dispatch_valid = '0;
        dispatch_uop = '{default: '0};
        ext_cdb = '0;
        seed = 32'd34497;
        errors = 0;
        done_cnt = 0;
        failed = 0;
        for (int r = 0; r < `PHY_REGS; r++) begin
            model_val[r] = '0;
            reg_ready[r] = (r == 0);
        end
        for (int r = 0; r < 32; r++) begin
            pending[r] = 1'b0;
        end

        // independent ops over all opcodes
        add_row(ADD, 1, 2, RS2, 0, 16, 0);
        add_row(SUB, 3, 4, RS2, 0, 17, 1);
        add_row(AND, 5, 6, RS2, 0, 18, 0);
        add_row(OR, 1, 0, IMM, 32'h0000_0f0f, 19, 0);
        add_row(XOR, 2, 0, IMM, 32'hffff_0000, 20, 1);
        add_row(SLT, 3, 4, RS2, 0, 21, 0);
        add_row(SLTU, 5, 0, IMM, 32'h8000_0000, 22, 0);
        add_row(SLL, 6, 0, IMM, 32'd7, 23, 0);
        add_row(SRL, 7, 8, RS2, 0, 24, 0);
        add_row(SRA, 8, 0, IMM, 32'd35, 25, 0);
        add_row(SRA, 7, 3, RS2, 0, 26, 1);
        // dependent chain
        add_row(ADD, 1, 0, IMM, 32'd5, 27, 0);
        add_row(SUB, 27, 2, RS2, 0, 28, 1);
        add_row(XOR, 28, 27, RS2, 0, 29, 0);
        add_row(SLL, 29, 0, IMM, 32'd4, 30, 0);
        // waits on external tag 40
        add_row(ADD, 40, 1, RS2, 0, 31, 0);
        add_row(SUB, 40, 0, IMM, 32'd9, 32, 1);
        // fills the station on external tag 41
        for (int k = 0; k < 8; k++) begin
            add_row(ADD, 41, 0, IMM, k, (k < 7) ? 33 + k : 42, k % 2);
        end
        // woken together by external tag 43
        add_row(AND, 43, 2, RS2, 0, 44, 0);
        add_row(OR, 43, 3, RS2, 0, 45, 1);
        add_row(XOR, 43, 0, IMM, 32'h5a5a_5a5a, 46, 0);

        add_test("independent ops", 0, 11, 0, 0, 0);
        add_test("dependent chain", 11, 4, 0, 0, 1);
        add_test("external wakeup", 15, 2, 40, 0, 0);
        add_test("station full", 17, 8, 41, 1, 0);
        add_test("oldest first", 25, 3, 43, 0, 1);

        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // idle after reset
        repeat (6) @(negedge clk);
        check_val("dispatch_ready", dispatch_ready, 1'b1);
        check_val("broadcast count", done_cnt, 0);
        $display("test 0 reset idle: %s", (errors == 0) ? "ok" : "FAILED");
        failed += (errors != 0);

        // preload source registers through the external slot
        for (int r = 1; r <= 8; r++) begin
            model_val[r] = lcg_next();
            send_ext(r, model_val[r]);
        end
        @(negedge clk);

        for (int t = 0; t < tests.size(); t++) begin
            int e0;
            e0 = errors;
            run_test(t);
            failed += (errors != e0);
        end

        $display("tests %0d, failed %0d, errors %0d", tests.size() + 1, failed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+common
common/int_issue_pkg.sv
verilog/one_hot_mux.sv
verilog/fu_alu.sv
verilog/phys_reg_file.sv
int_rs/int_rs_entry.sv
int_rs/int_rs.sv
verilog/int_issue_top.sv
verif/int_issue_props.sv
verif/int_issue_tb.sv

// ==== Bender.yml ====
package:
  name: int_issue

sources:
  - include_dirs:
      - common
    files:
      - common/int_issue_pkg.sv
      - verilog/one_hot_mux.sv
      - verilog/fu_alu.sv
      - verilog/phys_reg_file.sv
      - int_rs/int_rs_entry.sv
      - int_rs/int_rs.sv
      - verilog/int_issue_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/int_issue_props.sv
      - verif/int_issue_tb.sv
